// File: dv/rr_arb_tests.svh
/*
  Directed tests for the round-robin arbiter testbench.
  Included inside the testbench top; every task drives cycles through
  run_cycle, which checks against the model, and adds explicit checks.
*/

`ifndef RR_ARB_TESTS_SVH
`define RR_ARB_TESTS_SVH

// Outputs idle after reset and the first grant goes to client 0
task automatic reset_and_first_grant();
    test_name = "reset_and_first_grant";
    apply_reset();
    expect_bit(test_name, 1'b0, grant_valid);
    compare_vec(test_name, 4'b0000, grant);
    verify_id(test_name, 2'd0, grant_id);
    // Requests seen at the next edge and the grant one edge later
    run_cycle(4'b1111, 1'b0, 1'b0, '0);
    expect_bit(test_name, 1'b0, grant_valid);
    run_cycle(4'b1111, 1'b0, 1'b0, '0);
    expect_bit(test_name, 1'b1, grant_valid);
    compare_vec(test_name, 4'b0001, grant);
    verify_id(test_name, 2'd0, grant_id);
endtask

// All clients asking with the ack in the first grant cycle
task automatic rotate_all_clients();
    client_id_t rot_ids [5];
    rot_ids   = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd0};
    test_name = "rotate_all_clients";
    apply_reset();
    run_cycle(4'b1111, 1'b0, 1'b0, '0);
    for (int k = 0; k < 5; k++) begin
        // Last step drops the requests so the arbiter goes idle
        run_cycle((k == 4) ? 4'b0000 : 4'b1111, 1'b0, 1'b1, '0);
        verify_id(test_name, rot_ids[k], grant_id);
        compare_vec(test_name, onehot_of(rot_ids[k]), grant);
    end
endtask

// Random ack delay plus stray acks from other clients
task automatic hold_under_delay();
    client_vec_t held_vec;
    int          delay;
    test_name = "hold_under_delay";
    run_cycle(4'b1111, 1'b0, 1'b0, '0);
    for (int g = 0; g < 6; g++) begin
        run_cycle(4'b1111, 1'b0, 1'b0, 4'b1111);
        expect_bit(test_name, 1'b1, grant_valid);
        held_vec = expected_grant();
        delay    = $unsigned($random(seed)) % 4;
        repeat (delay) begin
            run_cycle(4'b1111, 1'b0, 1'b0, 4'b1111);
            compare_vec(test_name, held_vec, grant);
        end
        // Still the same grant in the ack cycle itself
        run_cycle(4'b1111, 1'b0, 1'b1, '0);
        compare_vec(test_name, held_vec, grant);
    end
endtask

// Lone requester acks and asks again
task automatic dead_cycle_rerequest();
    test_name = "dead_cycle_rerequest";
    run_cycle(4'b0000, 1'b0, 1'b1, '0);
    run_cycle(4'b0100, 1'b0, 1'b0, '0);
    expect_bit(test_name, 1'b0, grant_valid);
    run_cycle(4'b0100, 1'b0, 1'b1, '0);
    verify_id(test_name, 2'd2, grant_id);
    // One cycle without a grant
    run_cycle(4'b0100, 1'b0, 1'b0, '0);
    expect_bit(test_name, 1'b0, grant_valid);
    run_cycle(4'b0000, 1'b0, 1'b1, '0);
    expect_bit(test_name, 1'b1, grant_valid);
    verify_id(test_name, 2'd2, grant_id);
endtask

// Held grant releases while blocked and nothing new starts until block drops
task automatic block_gating();
    client_id_t held;
    test_name = "block_gating";
    run_cycle(4'b1111, 1'b0, 1'b0, '0);
    run_cycle(4'b1111, 1'b1, 1'b0, '0);
    expect_bit(test_name, 1'b1, grant_valid);
    held = model_id;
    run_cycle(4'b1111, 1'b1, 1'b1, '0);
    verify_id(test_name, held, grant_id);
    repeat (3) begin
        run_cycle(4'b1111, 1'b1, 1'b0, '0);
        expect_bit(test_name, 1'b0, grant_valid);
    end
    run_cycle(4'b1111, 1'b0, 1'b0, '0);
    expect_bit(test_name, 1'b0, grant_valid);
    // With everyone asking the client after the acked one wins
    run_cycle(4'b1111, 1'b0, 1'b1, '0);
    expect_bit(test_name, 1'b1, grant_valid);
    verify_id(test_name, client_id_t'(held + 1), grant_id);
endtask

// Random requests and acks with the model deciding every grant
task automatic sparse_random_requests();
    client_vec_t req;
    logic        ack_now;
    test_name = "sparse_random_requests";
    for (int n = 0; n < 60; n++) begin
        req     = client_vec_t'($random(seed));
        ack_now = ($random(seed) & 1) != 0;
        run_cycle(req, 1'b0, ack_now, '0);
    end
endtask

`endif

// File: dv/tb_rr_arbiter.sv
/*
  Testbench for the four-client round-robin arbiter.
  Drives the DUT on rising edges, steps its own last-winner model at
  each edge and compares grant, grant_id and grant_valid at the
  falling edge. The directed tests live in the included test file.
*/

`timescale 1ns/1ps
`default_nettype none

`include "rr_arb_params.svh"

module tb_rr_arbiter import rr_arb_pkg::*; ();

    // Run limit in clock cycles
    localparam int MAX_CYCLES = 2000;

    logic        clk;
    logic        arst_n;
    logic        block_arb;
    client_vec_t request;
    client_vec_t grant_ack;
    logic        grant_valid;
    client_vec_t grant;
    client_id_t  grant_id;

    // Inputs of the current cycle that the model consumes at the next edge
    client_vec_t drv_req;
    client_vec_t drv_ack;
    logic        drv_blk;

    // Reference model state
    logic        model_held;
    client_id_t  model_id;
    client_id_t  model_last;
    logic        model_last_valid;

    string       test_name;
    integer      seed;
    int          cycle_count = 0;

    rr_arbiter UUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .block_arb   (block_arb),
        .request     (request),
        .grant_ack   (grant_ack),
        .grant_valid (grant_valid),
        .grant       (grant),
        .grant_id    (grant_id)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Run limit and error exit
    // ------------------------------------------------------------------------

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------

    task automatic compare_vec(input string name, input client_vec_t exp, input client_vec_t act);
        if (exp !== act) begin
            $display("** Error [%s] grant: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic verify_id(input string name, input client_id_t exp, input client_id_t act);
        if (exp !== act) begin
            $display("** Error [%s] grant_id: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic expect_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error [%s] grant_valid: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------

    function automatic client_vec_t onehot_of(input client_id_t id);
        return client_vec_t'(1) << id;
    endfunction

    function automatic client_vec_t expected_grant();
        return model_held ? onehot_of(model_id) : '0;
    endfunction

    // First requester above the last acked winner, otherwise the lowest requester
    function automatic client_id_t pick_winner(input client_vec_t req);
        client_id_t pick;
        logic       found;
        pick  = '0;
        found = 1'b0;
        for (int i = 0; i < `RR_CLIENTS; i++) begin
            if (!found && req[i] && (!model_last_valid || i > int'(model_last))) begin
                pick  = client_id_t'(i);
                found = 1'b1;
            end
        end
        for (int i = 0; i < `RR_CLIENTS; i++) begin
            if (!found && req[i]) begin
                pick  = client_id_t'(i);
                found = 1'b1;
            end
        end
        return pick;
    endfunction

    // One clock edge of the arbiter as the handshake rules describe it
    task automatic advance_model();
        client_vec_t gated;
        gated = drv_blk ? '0 : drv_req;
        if (!model_held) begin
            if (gated != '0) begin
                model_held = 1'b1;
                model_id   = pick_winner(gated);
            end
        end else if (drv_ack[model_id]) begin
            model_last       = model_id;
            model_last_valid = 1'b1;
            // Back-to-back only if someone besides the acked client asks
            if ((gated & ~onehot_of(model_id)) != '0) begin
                model_id = pick_winner(gated);
            end else begin
                model_held = 1'b0;
                model_id   = '0;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Cycle driver
    // ------------------------------------------------------------------------

    // ack_held acks the grant visible in this cycle
    task automatic run_cycle(input client_vec_t req, input logic blk,
                             input logic ack_held, input client_vec_t ack_other);
        client_vec_t ack;
        @(posedge clk);
        advance_model();
        ack = ack_other & ~expected_grant();
        if (ack_held && model_held) begin
            ack = ack | onehot_of(model_id);
        end
        drv_req = req;
        drv_ack = ack;
        drv_blk = blk;
        request   <= req;
        grant_ack <= ack;
        block_arb <= blk;
        @(negedge clk);
        expect_bit(test_name, model_held, grant_valid);
        compare_vec(test_name, expected_grant(), grant);
        verify_id(test_name, model_id, grant_id);
    endtask

    // Reset held for 8 cycles with the model cleared alongside
    task automatic apply_reset();
        @(posedge clk);
        arst_n    <= 1'b0;
        request   <= '0;
        grant_ack <= '0;
        block_arb <= 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        drv_req          = '0;
        drv_ack          = '0;
        drv_blk          = 1'b0;
        model_held       = 1'b0;
        model_id         = '0;
        model_last       = '0;
        model_last_valid = 1'b0;
        @(negedge clk);
    endtask

    `include "rr_arb_tests.svh"

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------

    initial begin
        seed      = 17562;
        arst_n    = 1'b0;
        block_arb = 1'b0;
        request   = '0;
        grant_ack = '0;
        reset_and_first_grant();
        rotate_all_clients();
        hold_under_delay();
        dead_cycle_rerequest();
        block_gating();
        sparse_random_requests();
        $display("TB PASSED");
        $finish;
    end

endmodule : tb_rr_arbiter

`default_nettype wire

// File: hdl/rr_arb_params.svh
/*
  Sizing macros for the four-client round-robin arbiter.
  Included by the shared package and by every RTL block that
  loops over clients. The client count and the id width must agree.
*/

`ifndef RR_ARB_PARAMS_SVH
`define RR_ARB_PARAMS_SVH

// ---------------------------------------------------------------------------
// Arbiter sizing
// ---------------------------------------------------------------------------

// Number of requesting clients
`define RR_CLIENTS 4

// Width of a binary client id
// Must hold RR_CLIENTS-1
`define RR_ID_W 2

`endif

// File: hdl/rr_arb_pkg.sv
/*
  Types shared by the arbiter RTL and its testbench.
  Vector and id types carry the client count from the params header.
  Modules pull these in through a wildcard import in their header.
*/

`default_nettype none

`include "rr_arb_params.svh"

package rr_arb_pkg;

    // One bit per client
    // Requests, acknowledges, masks and the one-hot grant
    typedef logic [`RR_CLIENTS-1:0] client_vec_t;

    // Binary client index
    typedef logic [`RR_ID_W-1:0] client_id_t;

    // Grant controller FSM
    // IDLE means no grant held, HELD waits for the acknowledge pulse
    typedef enum logic {
        GS_IDLE = 1'b0,
        GS_HELD = 1'b1
    } grant_state_e;

endpackage : rr_arb_pkg

`default_nettype wire

// File: hdl/rr_arbiter.sv
/*
  Four-client round-robin arbiter with a held grant and ack pulse.
  A grant stays on until the granted client pulses grant_ack; the
  acked client then drops to lowest priority. block_arb gates all
  requests, so no new grant starts while it is high, though a grant
  already held still releases on its acknowledge.
*/

`timescale 1ns/1ps
`default_nettype none

module rr_arbiter import rr_arb_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        block_arb,
    input  client_vec_t request,
    input  client_vec_t grant_ack,
    output logic        grant_valid,
    output client_vec_t grant,
    output client_id_t  grant_id
);

    // Requests after block gating
    client_vec_t req_gated;

    // Requests above the last acked winner
    client_vec_t req_masked;

    // Encoder result
    client_id_t  winner;
    logic        winner_valid;

    // Ack of the held grant, one cycle
    logic        grant_release;

    // ------------------------------------------------------------------------
    // Request gating
    // ------------------------------------------------------------------------

    // Blocked means nobody is requesting as far as arbitration goes
    assign req_gated = block_arb ? '0 : request;

    // ------------------------------------------------------------------------
    // Datapath blocks
    // ------------------------------------------------------------------------

    rr_mask_gen u_mask_gen (
        .clk           (clk),
        .arst_n        (arst_n),
        .req_gated     (req_gated),
        .grant_release (grant_release),
        .grant_id      (grant_id),
        .req_masked    (req_masked)
    );

    rr_priority_enc u_priority_enc (
        .req_masked   (req_masked),
        .req_gated    (req_gated),
        .winner       (winner),
        .winner_valid (winner_valid)
    );

    rr_grant_ctrl u_grant_ctrl (
        .clk           (clk),
        .arst_n        (arst_n),
        .req_gated     (req_gated),
        .grant_ack     (grant_ack),
        .winner        (winner),
        .winner_valid  (winner_valid),
        .grant_release (grant_release),
        .grant_valid   (grant_valid),
        .grant         (grant),
        .grant_id      (grant_id)
    );

endmodule : rr_arbiter

`default_nettype wire

// File: hdl/rr_grant_ctrl.sv
/*
  Grant controller FSM for the round-robin arbiter.
  Registers the encoder winner into a one-hot grant and a binary id,
  holds them until the granted client pulses its acknowledge, then
  either loads the next winner on the same edge or drops to idle.
  Drives a release pulse back to the mask generator.
*/

`timescale 1ns/1ps
`default_nettype none

`include "rr_arb_params.svh"

module rr_grant_ctrl import rr_arb_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  client_vec_t req_gated,
    input  client_vec_t grant_ack,
    input  client_id_t  winner,
    input  logic        winner_valid,
    output logic        grant_release,
    output logic        grant_valid,
    output client_vec_t grant,
    output client_id_t  grant_id
);

    // FSM state
    grant_state_e state_q;
    grant_state_e state_d;

    // Next values of the grant registers
    client_vec_t  grant_d;
    client_id_t   grant_id_d;

    // Winner as a one-hot vector
    client_vec_t  winner_vec;

    // Requests from anyone but the current holder
    client_vec_t  other_req;
    logic         other_any;

    // ------------------------------------------------------------------------
    // Handshake decode
    // ------------------------------------------------------------------------

    // Only the ack bit of the held id counts
    // Ack bits of other clients are ignored
    assign grant_release = (state_q == GS_HELD) && grant_ack[grant_id];

    assign other_req = req_gated & ~grant;
    assign other_any = |other_req;

    assign winner_vec = client_vec_t'(1) << winner;

    // ------------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------------

    always_comb begin
        state_d    = state_q;
        grant_d    = grant;
        grant_id_d = grant_id;

        case (state_q)
            GS_IDLE: begin
                // First grant one edge after the requests show up
                if (winner_valid) begin
                    state_d    = GS_HELD;
                    grant_d    = winner_vec;
                    grant_id_d = winner;
                end
            end

            GS_HELD: begin
                if (grant_release) begin
                    if (other_any && winner_valid) begin
                        // Back-to-back grant
                        // Mask already skips the acked client
                        grant_d    = winner_vec;
                        grant_id_d = winner;
                    end else begin
                        // Only the acked client left, or blocked
                        // One dead cycle before anything new
                        state_d    = GS_IDLE;
                        grant_d    = '0;
                        grant_id_d = '0;
                    end
                end
                // No ack: hold everything, the arbiter stalls
            end

            default: begin
                state_d    = GS_IDLE;
                grant_d    = '0;
                grant_id_d = '0;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= GS_IDLE;
            grant    <= '0;
            grant_id <= '0;
        end else begin
            state_q  <= state_d;
            grant    <= grant_d;
            grant_id <= grant_id_d;
        end
    end

    // Valid straight from the state flop
    assign grant_valid = (state_q == GS_HELD);

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    // One-hot grant agrees with the binary id
    a_grant_onehot: assert property (
        @(posedge clk) disable iff (!arst_n)
        grant_valid |-> ($onehot(grant) && (grant == (client_vec_t'(1) << grant_id)))
    );

    // Held grant does not move until acked
    a_grant_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        (grant_valid && !grant_release) |=>
            (grant_valid && $stable(grant) && $stable(grant_id))
    );

endmodule : rr_grant_ctrl

`default_nettype wire

// File: hdl/rr_mask_gen.sv
/*
  Rotating priority mask for the round-robin arbiter.
  Remembers the last acknowledged winner and keeps only the gated
  requests of clients above it. Before any acknowledge all gated
  requests pass, so the search starts at client 0 after reset.
  The winner being released this cycle already counts as the last one.
*/

`timescale 1ns/1ps
`default_nettype none

`include "rr_arb_params.svh"

module rr_mask_gen import rr_arb_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  client_vec_t req_gated,
    input  logic        grant_release,
    input  client_id_t  grant_id,
    output client_vec_t req_masked
);

    // Last acknowledged winner and its valid flag
    client_id_t  last_id_q;
    logic        last_valid_q;

    // Reference point for the mask in this cycle
    client_id_t  ref_id;
    logic        ref_valid;
    client_vec_t rr_mask;

    // ------------------------------------------------------------------------
    // Last-winner register
    // ------------------------------------------------------------------------

    // Updated only on the edge that samples the acknowledge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_id_q    <= '0;
            last_valid_q <= 1'b0;
        end else if (grant_release) begin
            last_id_q    <= grant_id;
            last_valid_q <= 1'b1;
        end
    end

    // Bypass the register during release
    // so the next grant on that same edge already skips the acked client
    assign ref_id    = grant_release ? grant_id : last_id_q;
    assign ref_valid = grant_release | last_valid_q;

    // ------------------------------------------------------------------------
    // Mask build and apply
    // ------------------------------------------------------------------------

    // Bit i survives if client i sits strictly above the reference
    // With no reference yet everything passes
    always_comb begin
        for (int i = 0; i < `RR_CLIENTS; i++) begin
            rr_mask[i] = !ref_valid || (i > int'(ref_id));
        end
    end

    assign req_masked = req_gated & rr_mask;

    // Release comes from the controller with the id it holds
    // That id must be a known value naming a real client
    a_release_id_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        grant_release |-> (!$isunknown(grant_id) && (int'(grant_id) < `RR_CLIENTS))
    );

endmodule : rr_mask_gen

`default_nettype wire

// File: hdl/rr_priority_enc.sv
/*
  Two-level find-first-set for the round-robin arbiter.
  Picks the lowest set bit of the masked requests. When the mask
  removes every request the search wraps to the lowest set bit of
  all gated requests. Purely combinational.
*/

`timescale 1ns/1ps
`default_nettype none

`include "rr_arb_params.svh"

module rr_priority_enc import rr_arb_pkg::*; (
    input  client_vec_t req_masked,
    input  client_vec_t req_gated,
    output client_id_t  winner,
    output logic        winner_valid
);

    // Per-level results
    client_id_t masked_id;
    client_id_t gated_id;
    logic       masked_hit;

    // ------------------------------------------------------------------------
    // Find first set
    // ------------------------------------------------------------------------

    // Lowest index wins
    // Scan downward so the last hit is the lowest one
    function automatic client_id_t first_set(input client_vec_t vec);
        client_id_t idx;
        idx = '0;
        for (int i = `RR_CLIENTS - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = client_id_t'(i);
            end
        end
        return idx;
    endfunction

    // Upper level: clients above the last winner
    assign masked_hit = |req_masked;
    assign masked_id  = first_set(req_masked);

    // Lower level: wrap-around over every gated request
    assign gated_id = first_set(req_gated);

    // ------------------------------------------------------------------------
    // Winner select
    // ------------------------------------------------------------------------

    // Masked level has priority, wrap only when it is empty
    assign winner = masked_hit ? masked_id : gated_id;

    // Any gated request yields a winner
    // Masked bits are a subset of the gated ones
    assign winner_valid = |req_gated;

endmodule : rr_priority_enc

`default_nettype wire

// File: tb.f
+incdir+hdl
+incdir+dv
hdl/rr_arb_pkg.sv
hdl/rr_mask_gen.sv
hdl/rr_priority_enc.sv
hdl/rr_grant_ctrl.sv
hdl/rr_arbiter.sv
dv/tb_rr_arbiter.sv
